// ==== display_patterns.txt ====
// count_a count_b seg0 seg1 seg2 seg3, all hex, segs active low with bit 0 as segment a
// seg0 seg1 are tens and ones of count_a, seg2 seg3 those of count_b
07 2A 7F 78 19 24
63 0A 10 10 79 40
00 37 7F 40 12 12
64 17 3F 3F 24 30
44 7F 02 00 3F 3F
7F 64 3F 3F 3F 3F
1F 56 30 79 00 02
09 00 7F 10 7F 40
32 01 12 40 7F 79
13 40 79 10 02 19
70 4B 3F 3F 78 12
14 63 24 40 10 10
30 25 19 00 30 78
42 65 02 02 3F 3F

// ==== display.f ====
+incdir+.
count_pkg.sv
seg_pkg.sv
digit_wr_if.sv
channel_loader.sv
wr_arbiter.sv
display_scanner.sv
display_top.sv
display_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds the display testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f display.f --top-module display_tb -o display_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/display_sim > sim.log 2>&1

grep -qx "No errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }

// ==== display_tb.sv ====
// testbench for the two-count display that replays the pattern file and random count bursts
`timescale 1ns/1ns
`include "display_consts.svh"

module display_tb;
	import count_pkg::*;
	import seg_pkg::*;

	localparam int NUM_FILE_TESTS = 14; // lines in the pattern file
	localparam int NUM_RAND_TESTS = 3; // random burst tests
	localparam int BURST_LEN = 4; // consecutive count changes per burst
	localparam int NUM_TESTS = NUM_FILE_TESTS + NUM_RAND_TESTS + 1; // plus the reset check
	localparam int SETTLE_CYCLES = 3 + 4 * `SCAN_DIV; // visibility bound after a change
	localparam int SCAN_CYCLES = `NUM_DIGITS * `SCAN_DIV; // one full scan
	localparam time TIME_LIMIT = time'((NUM_TESTS + 2) * (3 + 8 * `SCAN_DIV) * 8);

	logic clk;
	logic rst_n;
	count_t count_a;
	count_t count_b;
	seg_t seg;
	digit_sel_t digit_sel;

	logic [7:0] pat_mem [0:NUM_FILE_TESTS*6-1]; // count_a, count_b, four seg per test
	seg_t exp_seg [`NUM_DIGITS]; // expected pattern per scan position
	logic [31:0] rng_state; // xorshift state

	display_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.count_a(count_a),
		.count_b(count_b),
		.seg(seg),
		.digit_sel(digit_sel)
	);

	always #4 clk = ~clk; // 8 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// active-low pattern of a decimal digit with bit 0 as segment a
	function automatic seg_t digit_pattern(input int d);
		seg_t p;
		case (d)
			0: p = 7'h40;
			1: p = 7'h79;
			2: p = 7'h24;
			3: p = 7'h30;
			4: p = 7'h19;
			5: p = 7'h12;
			6: p = 7'h02;
			7: p = 7'h78;
			8: p = 7'h00;
			9: p = 7'h10;
			default: p = SEG_BLANK;
		endcase
		return p;
	endfunction

	// what one channel shows with dashes above 99 and no leading zero
	function automatic void count_patterns(input count_t value, output seg_t tens,
			output seg_t ones);
		int v;
		v = int'(value);
		if (v > 99) begin
			tens = SEG_DASH;
			ones = SEG_DASH;
		end else begin
			tens = (v / 10 == 0) ? SEG_BLANK : digit_pattern(v / 10);
			ones = digit_pattern(v % 10);
		end
	endfunction

	// active-low enable of one scan position
	function automatic digit_sel_t sel_for(input logic [1:0] pos);
		digit_sel_t sel;
		case (pos)
			2'd0: sel = 4'b1110;
			2'd1: sel = 4'b1101;
			2'd2: sel = 4'b1011;
			default: sel = 4'b0111;
		endcase
		return sel;
	endfunction

	task automatic check_seg(input seg_t actual, input seg_t expected, input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s, seg %h expected %h", $time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_sel(input digit_sel_t actual, input digit_sel_t expected,
			input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s, digit_sel %b expected %b", $time, what, actual,
				expected);
			$display("Errors found");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic apply_counts(input count_t a, input count_t b);
		@(posedge clk);
		#1;
		count_a = a; // driven just after the edge
		count_b = b;
	endtask

	// samples one full scan at falling edges and checks order, dwell and patterns
	task automatic observe_scan(input string what);
		digit_sel_t prev_sel;
		digit_sel_t exp_sel;
		logic [1:0] pos;
		int run;
		bit first_run;
		@(negedge clk);
		pos = 2'd0;
		case (digit_sel)
			4'b1110: pos = 2'd0;
			4'b1101: pos = 2'd1;
			4'b1011: pos = 2'd2;
			4'b0111: pos = 2'd3;
			default: check_sel(digit_sel, sel_for(2'd0), {what, ", no single digit enabled"});
		endcase
		check_seg(seg, exp_seg[pos], what);
		prev_sel = digit_sel;
		run = 1;
		first_run = 1'b1; // scan phase unknown at the start
		for (int c = 1; c < SCAN_CYCLES; c++) begin
			@(negedge clk);
			if (run == `SCAN_DIV)
				exp_sel = sel_for(pos + 2'd1); // next digit due after a full dwell
			else if (!first_run)
				exp_sel = prev_sel;
			else if (digit_sel == sel_for(pos + 2'd1))
				exp_sel = digit_sel; // partial first dwell ended
			else
				exp_sel = prev_sel;
			check_sel(digit_sel, exp_sel, what);
			if (digit_sel == prev_sel) begin
				run++;
			end else begin
				run = 1;
				first_run = 1'b0;
				pos = pos + 2'd1;
			end
			prev_sel = digit_sel;
			check_seg(seg, exp_seg[pos], what);
		end
	endtask

	initial begin
		#(TIME_LIMIT);
		$display("Timeout: the tests did not finish within %0t ns", TIME_LIMIT);
		$display("Errors found");
		$fatal(1, "watchdog stopped the run");
	end

	initial begin
		count_t a;
		count_t b;
		clk = 1'b0;
		rst_n = 1'b0;
		count_a = '0;
		count_b = '0;
		rng_state = 32'd3; // fixed seed
		$readmemh("display_patterns.txt", pat_mem);
		if ($isunknown(pat_mem[0]) || $isunknown(pat_mem[NUM_FILE_TESTS*6-1])) begin
			$display("The pattern file display_patterns.txt is missing or too short");
			$display("Errors found");
			$fatal(1, "no stimulus");
		end
		@(negedge clk);
		check_sel(digit_sel, '1, "in reset"); // nothing enabled
		check_seg(seg, SEG_BLANK, "in reset");
		@(posedge clk);
		#1;
		rst_n = 1'b1; // two rising edges in reset
		@(posedge clk);
		for (int d = 0; d < `NUM_DIGITS; d++) begin
			exp_seg[d] = SEG_BLANK; // store still blank
		end
		observe_scan("after reset");
		for (int t = 0; t < NUM_FILE_TESTS; t++) begin
			a = pat_mem[t*6][6:0];
			b = pat_mem[t*6+1][6:0];
			for (int d = 0; d < `NUM_DIGITS; d++) begin
				exp_seg[d] = pat_mem[t*6+2+d][6:0];
			end
			apply_counts(a, b); // both counts change so the arbiter sees contention
			repeat (SETTLE_CYCLES) @(posedge clk);
			observe_scan($sformatf("file test %0d", t));
		end
		for (int r = 0; r < NUM_RAND_TESTS; r++) begin
			for (int k = 0; k < BURST_LEN; k++) begin
				rng_state = xorshift(rng_state);
				a = rng_state[6:0];
				rng_state = xorshift(rng_state);
				b = rng_state[6:0];
				apply_counts(a, b); // new value every cycle
			end
			count_patterns(a, exp_seg[0], exp_seg[1]); // only the last value counts
			count_patterns(b, exp_seg[2], exp_seg[3]);
			repeat (SETTLE_CYCLES) @(posedge clk);
			observe_scan($sformatf("burst test %0d", r));
		end
		$display("No errors");
		$finish;
	end

endmodule

// ==== display_top.sv ====
// two-count seven-segment display, loaders share the digit store via an arbiter
`timescale 1ns/1ns

module display_top (
	input logic clk,
	input logic rst_n,
	input count_pkg::count_t count_a,
	input count_pkg::count_t count_b,
	output seg_pkg::seg_t seg,
	output seg_pkg::digit_sel_t digit_sel
);
	import count_pkg::*;

	digit_wr_if wr_a (); // loader a to arbiter
	digit_wr_if wr_b (); // loader b to arbiter

	logic wr_en; // store write strobe
	wr_payload_t wr_payload; // winning slot and digit pair

	channel_loader #(.SLOT(1'b0)) i_loader_a (
		.clk(clk),
		.rst_n(rst_n),
		.count(count_a),
		.wr(wr_a.requester)
	);

	channel_loader #(.SLOT(1'b1)) i_loader_b (
		.clk(clk),
		.rst_n(rst_n),
		.count(count_b),
		.wr(wr_b.requester)
	);

	wr_arbiter #(.payload_t(wr_payload_t)) i_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.req_a(wr_a.arbiter),
		.req_b(wr_b.arbiter),
		.wr_en(wr_en),
		.wr_payload(wr_payload)
	);

	display_scanner i_scanner (
		.clk(clk),
		.rst_n(rst_n),
		.wr_en(wr_en),
		.wr_payload(wr_payload),
		.seg(seg),
		.digit_sel(digit_sel)
	);

endmodule

// ==== display_scanner.sv ====
// digit store with multiplexed scan driving segments and digit enables
`timescale 1ns/1ns
`include "display_consts.svh"

module display_scanner (
	input logic clk,
	input logic rst_n,
	input logic wr_en,
	input count_pkg::wr_payload_t wr_payload,
	output seg_pkg::seg_t seg,
	output seg_pkg::digit_sel_t digit_sel
);
	import count_pkg::*;
	import seg_pkg::*;

	localparam int unsigned DIV_LAST = `SCAN_DIV - 1; // last cycle of a digit

	bcd_digit_t store [`NUM_DIGITS]; // 0,1 channel a and 2,3 channel b
	logic [`SCAN_CNT_W-1:0] div_cnt; // cycles spent on current digit
	logic [`DIGIT_IDX_W-1:0] digit_idx; // digit being scanned
	logic scan_step; // move to next digit

	// store is reset to blank so the display stays dark until a first write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_DIGITS; i++) begin
				store[i] <= BCD_BLANK;
			end
		end else if (wr_en) begin
			store[{wr_payload.slot, 1'b0}] <= wr_payload.pair.tens; // left digit of pair
			store[{wr_payload.slot, 1'b1}] <= wr_payload.pair.ones;
		end
	end

	assign scan_step = (div_cnt == DIV_LAST[`SCAN_CNT_W-1:0]);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			digit_idx <= '0;
		end else if (scan_step) begin
			div_cnt <= '0;
			digit_idx <= digit_idx + 1'b1; // wraps 3 to 0
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// pattern and enable registered together so they switch on the same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			seg <= SEG_BLANK;
			digit_sel <= DIGIT_SEL_OFF;
		end else begin
			seg <= encode_digit(store[digit_idx]);
			digit_sel <= ~(digit_sel_t'(1) << digit_idx); // active low
		end
	end

	// two enabled digits would short the shared segment lines
	a_sel_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(~digit_sel)
	) else $error("more than one digit enabled");

endmodule

// ==== wr_arbiter.sv ====
// round-robin arbiter for the single write port of the digit store
`timescale 1ns/1ns
`include "display_consts.svh"

module wr_arbiter #(
	parameter type payload_t = count_pkg::wr_payload_t
) (
	input logic clk,
	input logic rst_n,
	digit_wr_if.arbiter req_a,
	digit_wr_if.arbiter req_b,
	output logic wr_en,
	output payload_t wr_payload
);

	logic [`NUM_CHANNELS-1:0] req_vec; // bit 0 loader a, bit 1 loader b
	logic [`NUM_CHANNELS-1:0] gnt_vec; // at most one bit set
	logic last_b; // loader b got the previous grant
	payload_t pay_vec [`NUM_CHANNELS]; // payload offered by each loader

	assign req_vec = {req_b.req, req_a.req};
	assign pay_vec[0] = payload_t'({req_a.slot, req_a.pair}); // slot above pair
	assign pay_vec[1] = payload_t'({req_b.slot, req_b.pair});

	// same-cycle grant, on contention the loader not served last wins
	always_comb begin
		gnt_vec = '0;
		if (req_vec[0] && (!req_vec[1] || last_b))
			gnt_vec[0] = 1'b1;
		else if (req_vec[1])
			gnt_vec[1] = 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			last_b <= 1'b1; // loader a goes first
		else if (|gnt_vec)
			last_b <= gnt_vec[1];
	end

	assign req_a.gnt = gnt_vec[0];
	assign req_b.gnt = gnt_vec[1];

	assign wr_en = |gnt_vec; // store writes at this edge
	assign wr_payload = gnt_vec[1] ? pay_vec[1] : pay_vec[0];

	// two writes in one cycle would lose a pair
	a_gnt_excl: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(req_a.gnt && req_b.gnt)
	) else $error("both loaders granted");

	// a loader drops req after gnt, a stray gnt would write stale data
	a_gnt_req: assert property (
		@(posedge clk) disable iff (!rst_n)
		(gnt_vec & ~req_vec) == '0
	) else $error("gnt without req");

endmodule

// ==== channel_loader.sv ====
// channel loader, converts a changed count to BCD and requests a store write
`timescale 1ns/1ns

module channel_loader #(
	parameter bit SLOT = 1'b0 // digit pair this channel owns in the store
) (
	input logic clk,
	input logic rst_n,
	input count_pkg::count_t count,
	digit_wr_if.requester wr
);
	import count_pkg::*;

	count_t last_count; // count seen at the previous edge
	bcd_pair_t pend_pair; // newest converted pair, waits for gnt
	logic pend_req; // a write is outstanding
	logic changed; // count differs from the last one seen

	assign changed = (count != last_count);

	// a reset count of zero matches the blank store, so nothing is written
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_count <= '0;
			pend_req <= 1'b0;
		end else begin
			last_count <= count;
			if (changed)
				pend_req <= 1'b1; // new value, keep asking even if granted now
			else if (wr.gnt)
				pend_req <= 1'b0; // written, drop req next cycle
		end
	end

	// payload register, replaced whenever a newer count arrives
	always_ff @(posedge clk) begin
		if (changed)
			pend_pair <= to_bcd_pair(count);
	end

	assign wr.req = pend_req;
	assign wr.slot = SLOT; // fixed per instance
	assign wr.pair = pend_pair;

	// the arbiter may sample the payload late, so it must not move while waiting
	a_pair_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		(wr.req && !wr.gnt && !changed) |=> $stable(wr.pair)
	) else $error("pair moved while waiting for gnt");

endmodule

// ==== digit_wr_if.sv ====
// write request link from one channel loader to the digit store arbiter
`timescale 1ns/1ns

interface digit_wr_if;

	logic req; // level, held until gnt is seen
	logic gnt; // one-cycle strobe, store written at this edge
	logic slot; // target digit pair in the store
	count_pkg::bcd_pair_t pair; // tens and ones codes to write

	modport requester (
		output req,
		output slot,
		output pair,
		input gnt
	);

	modport arbiter (
		input req,
		input slot,
		input pair,
		output gnt
	);

endinterface

// ==== seg_pkg.sv ====
// segment-side types, active-low segment patterns and the digit encoder
`include "display_consts.svh"

package seg_pkg;

	typedef logic [6:0] seg_t; // active low, bit 0 is segment a, bit 6 is g
	typedef logic [`NUM_DIGITS-1:0] digit_sel_t; // active-low one-hot enable

	localparam seg_t SEG_BLANK = 7'h7f; // every segment off
	localparam seg_t SEG_DASH = 7'h3f; // only segment g lit
	localparam digit_sel_t DIGIT_SEL_OFF = '1; // no digit enabled

	// maps a digit code to its pattern, unused codes stay dark
	function automatic seg_t encode_digit(input count_pkg::bcd_digit_t code);
		seg_t pattern;
		case (code)
			4'd0: pattern = 7'h40; // a b c d e f
			4'd1: pattern = 7'h79; // b c
			4'd2: pattern = 7'h24; // a b d e g
			4'd3: pattern = 7'h30; // a b c d g
			4'd4: pattern = 7'h19; // b c f g
			4'd5: pattern = 7'h12; // a c d f g
			4'd6: pattern = 7'h02; // a c d e f g
			4'd7: pattern = 7'h78; // a b c
			4'd8: pattern = 7'h00; // all segments
			4'd9: pattern = 7'h10; // a b c d f g
			count_pkg::BCD_DASH: pattern = SEG_DASH;
			default: pattern = SEG_BLANK; // blank code and spare codes
		endcase
		return pattern;
	endfunction

endpackage

// ==== count_pkg.sv ====
// count-side types and the binary to BCD conversion used by the loaders
package count_pkg;

	typedef logic [6:0] count_t; // binary count, 0 to 127
	typedef logic [3:0] bcd_digit_t; // 0-9 digits, 14 dash, 15 blank

	localparam bcd_digit_t BCD_DASH = 4'd14; // shown for counts above 99
	localparam bcd_digit_t BCD_BLANK = 4'd15; // leading zero and reset value

	typedef struct packed {
		bcd_digit_t tens; // left digit of the channel
		bcd_digit_t ones; // right digit
	} bcd_pair_t;

	typedef struct packed {
		logic slot; // 0 is channel a, 1 is channel b
		bcd_pair_t pair;
	} wr_payload_t;

	// double dabble over the 7 count bits, two BCD digits are enough up to 99
	function automatic bcd_pair_t to_bcd_pair(input count_t value);
		logic [7:0] bcd;
		bcd_pair_t result;
		bcd = '0;
		for (int i = $bits(count_t) - 1; i >= 0; i--) begin
			if (bcd[3:0] >= 4'd5) bcd[3:0] = bcd[3:0] + 4'd3; // ones nibble correction
			if (bcd[7:4] >= 4'd5) bcd[7:4] = bcd[7:4] + 4'd3; // tens nibble correction
			bcd = {bcd[6:0], value[i]}; // shift in next bit, msb first
		end
		result.tens = bcd[7:4];
		result.ones = bcd[3:0];
		if (value > 7'd99) begin
			result.tens = BCD_DASH; // out of range, two dashes
			result.ones = BCD_DASH;
		end else if (result.tens == 4'd0) begin
			result.tens = BCD_BLANK; // suppress leading zero
		end
		return result;
	endfunction

endpackage

// ==== display_consts.svh ====
// display constants shared by the loaders, the store arbiter and the scan logic
`ifndef DISPLAY_CONSTS_SVH
`define DISPLAY_CONSTS_SVH

// loaders that share the single store write port
`define NUM_CHANNELS 2

// digits on the display, tens and ones for each channel
`define NUM_DIGITS 4

// clock cycles each digit stays enabled, kept short for simulation
`define SCAN_DIV 4

// counter widths derived from the sizes above
`define SCAN_CNT_W $clog2(`SCAN_DIV)
`define DIGIT_IDX_W $clog2(`NUM_DIGITS)

`endif
